/* Bender.yml */
package:
  name: store_unit

sources:
  - store_pkg.sv
  - wr_aligner.sv
  - store_sequencer.sv
  - write_fifo.sv
  - mem_write_port.sv
  - store_unit_top.sv
  - target: simulation
    files:
      - tb_store_unit.sv

/* mem_write_port.sv */
`timescale 1ns/1ps

module mem_write_port import store_pkg::*; #(
	parameter int RAM_WORDS = 16
) (
	input  logic       bclk,
	input  logic       rst_n,
	input  logic       empty,
	input  packet_t    head_pkt,
	output logic       pop,
	input  word_addr_t rd_addr,
	output word_t      rd_data
);

	word_t    ram [RAM_WORDS];
	word_t    wr_data;
	byte_en_t byte_en;

	// The write lands on the same edge that removes the packet from the FIFO.
	assign pop = !empty;

	wr_aligner u_wr_aligner (
		.packet  (head_pkt.code),
		.operand (head_pkt.operand),
		.size    (head_pkt.size),
		.wr_data (wr_data),
		.byte_en (byte_en)
	);

	always_ff @(posedge bclk) begin
		if (pop) begin
			for (int i = 0; i < $bits(byte_en_t); i++) begin
				if (byte_en[i])
					ram[head_pkt.word_addr][8*i +: 8] <= wr_data[8*i +: 8];
			end
		end
		rd_data <= ram[rd_addr]; // Read data follows the address by one cycle.
	end

	a_ram_size: assert property (@(posedge bclk) disable iff (!rst_n)
		RAM_WORDS == 2 ** $bits(word_addr_t))
		else $error("RAM_WORDS does not match the word address width.");

	// Every packet the sequencer emits must touch at least one byte.
	a_byte_en_nonzero: assert property (@(posedge bclk) disable iff (!rst_n)
		pop |-> byte_en != '0)
		else $error("Packet popped with no byte lane enabled.");

endmodule

/* sim.f */
store_pkg.sv
wr_aligner.sv
store_sequencer.sv
write_fifo.sv
mem_write_port.sv
store_unit_top.sv
tb_store_unit.sv

/* store_pkg.sv */
package store_pkg;

	// Store size codes, as seen on the request and carried in every packet.
	typedef enum logic [1:0] {
		size_byte   = 2'b00,
		size_word   = 2'b01,
		size_double = 2'b10,
		size_quad   = 2'b11
	} size_t;

	typedef logic [5:0]  byte_addr_t; // 64 bytes of RAM.
	typedef logic [3:0]  word_addr_t;
	typedef logic [1:0]  lane_t;

	// Upper two bits hold the packet index, lower two the start lane.
	typedef logic [3:0]  pkt_code_t;

	typedef logic [63:0] operand_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0]  byte_en_t;

	// One word-sized slice of a store as it travels through the FIFO.
	typedef struct packed {
		word_addr_t word_addr;
		pkt_code_t  code;
		size_t      size;
		operand_t   operand;
	} packet_t;

	typedef enum logic {
		seq_idle,
		seq_next
	} seq_state_t;

endpackage

/* store_sequencer.sv */
`timescale 1ns/1ps

module store_sequencer import store_pkg::*; (
	input  logic       bclk,
	input  logic       rst_n,
	input  logic       req,
	input  byte_addr_t req_addr,
	input  size_t      req_size,
	input  operand_t   req_operand,
	input  logic       full,
	output logic       ready,
	output logic       busy,
	output logic       push,
	output packet_t    push_pkt
);

	seq_state_t state;
	logic       accept;
	logic [1:0] req_last;  // Index of the last packet for the incoming request.
	logic [1:0] last_k;
	logic [1:0] pkt_k;     // Packet number within the current store.
	logic [1:0] pkt_idx;
	word_addr_t cur_word;
	lane_t      lat_lane;
	size_t      lat_size;
	operand_t   lat_operand;

	assign ready  = (state == seq_idle);
	assign busy   = (state == seq_next);
	assign accept = req && ready;
	assign push   = busy && !full; // Stall while the FIFO is full.

	// Number of packets depends on how far the store spills past its first word.
	always_comb begin
		case (req_size)
			size_byte:   req_last = 2'd0;
			size_word:   req_last = (req_addr[1:0] == 2'd3) ? 2'd1 : 2'd0;
			size_double: req_last = (req_addr[1:0] != 2'd0) ? 2'd1 : 2'd0;
			size_quad:   req_last = (req_addr[1:0] == 2'd0) ? 2'd1 : 2'd2;
			default:     req_last = 2'd0;
		endcase
	end

	// A quad numbers its packets straight through. Other sizes jump from first to last.
	assign pkt_idx = (lat_size == size_quad) ? pkt_k : {pkt_k[0], 1'b0};

	assign push_pkt = '{
		word_addr: cur_word,
		code:      {pkt_idx, lat_lane},
		size:      lat_size,
		operand:   lat_operand
	};

	always_ff @(posedge bclk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= seq_idle;
			pkt_k  <= '0;
			last_k <= '0;
		end else begin
			case (state)
				seq_idle: begin
					if (accept) begin
						state  <= seq_next;
						pkt_k  <= '0;
						last_k <= req_last;
					end
				end
				seq_next: begin
					if (push) begin
						if (pkt_k == last_k)
							state <= seq_idle;
						else
							pkt_k <= pkt_k + 1'b1;
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

	always_ff @(posedge bclk) begin
		if (accept) begin
			cur_word    <= req_addr[5:2];
			lat_lane    <= req_addr[1:0];
			lat_size    <= req_size;
			lat_operand <= req_operand;
		end else if (push) begin
			cur_word <= cur_word + 1'b1; // Wraps at the end of the RAM.
		end
	end

	a_req_when_ready: assert property (@(posedge bclk) disable iff (!rst_n)
		req |-> ready)
		else $error("Store request arrived while the sequencer was not ready.");

endmodule

/* store_unit_top.sv */
`timescale 1ns/1ps

module store_unit_top import store_pkg::*; #(
	parameter int FIFO_DEPTH = 4,
	parameter int RAM_WORDS  = 16
) (
	input  logic       bclk,
	input  logic       rst_n,
	input  logic       req,
	input  byte_addr_t req_addr,
	input  size_t      req_size,
	input  operand_t   req_operand,
	input  word_addr_t rd_addr,
	output logic       ready,
	output logic       idle,
	output word_t      rd_data
);

	logic    busy;
	logic    push;
	logic    pop;
	logic    full;
	logic    empty;
	packet_t push_pkt;
	packet_t head_pkt;

	store_sequencer u_store_sequencer (
		.bclk        (bclk),
		.rst_n       (rst_n),
		.req         (req),
		.req_addr    (req_addr),
		.req_size    (req_size),
		.req_operand (req_operand),
		.full        (full),
		.ready       (ready),
		.busy        (busy),
		.push        (push),
		.push_pkt    (push_pkt)
	);

	write_fifo #(
		.DEPTH (FIFO_DEPTH)
	) u_write_fifo (
		.bclk     (bclk),
		.rst_n    (rst_n),
		.push     (push),
		.push_pkt (push_pkt),
		.pop      (pop),
		.head_pkt (head_pkt),
		.full     (full),
		.empty    (empty)
	);

	mem_write_port #(
		.RAM_WORDS (RAM_WORDS)
	) u_mem_write_port (
		.bclk     (bclk),
		.rst_n    (rst_n),
		.empty    (empty),
		.head_pkt (head_pkt),
		.pop      (pop),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

	// Nothing left in flight once the sequencer is done and the FIFO has drained.
	assign idle = !busy && empty;

endmodule

/* tb_store_unit.sv */
`timescale 1ns/1ps

module tb_store_unit import store_pkg::*; ();

	localparam int WAIT_LIMIT = 200;
	localparam int NUM_WORDS  = 16;

	logic       bclk;
	logic       rst_n;
	logic       req;
	byte_addr_t req_addr;
	size_t      req_size;
	operand_t   req_operand;
	word_addr_t rd_addr;
	logic       ready;
	logic       idle;
	word_t      rd_data;

	logic [7:0]  model_mem [64]; // One entry per RAM byte.
	logic [31:0] rng_state;

	store_unit_top #(
		.FIFO_DEPTH (4),
		.RAM_WORDS  (NUM_WORDS)
	) u_store_unit_top (
		.bclk        (bclk),
		.rst_n       (rst_n),
		.req         (req),
		.req_addr    (req_addr),
		.req_size    (req_size),
		.req_operand (req_operand),
		.rd_addr     (rd_addr),
		.ready       (ready),
		.idle        (idle),
		.rd_data     (rd_data)
	);

	initial begin
		bclk = 1'b0;
		forever #4 bclk = ~bclk;
	end

	function automatic logic [31:0] next_random();
		logic [31:0] s;
		s = rng_state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rng_state = s;
		return s;
	endfunction

	// Bytes land at consecutive addresses, lowest operand byte first.
	task automatic model_store(input byte_addr_t addr, input size_t size, input operand_t op);
		int nbytes;
		nbytes = 1 << size;
		for (int i = 0; i < nbytes; i++) begin
			if (size == size_quad)
				model_mem[byte_addr_t'(addr + i)] = op[8*i +: 8];
			else
				model_mem[byte_addr_t'(addr + i)] = op[32 + 8*i +: 8];
		end
	endtask

	function automatic word_t model_word(input word_addr_t w);
		return {model_mem[{w, 2'd3}], model_mem[{w, 2'd2}],
			model_mem[{w, 2'd1}], model_mem[{w, 2'd0}]};
	endfunction

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic check_level(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string level_name);
		$display("Timeout: %s never went high within %0d cycles.", level_name, WAIT_LIMIT);
		$display("Verification failed");
		$fatal(1);
	endtask

	// All tasks below start and end on a falling edge.
	task automatic issue_store(input byte_addr_t addr, input size_t size, input operand_t op);
		int waited;
		waited = 0;
		while (!ready) begin
			if (waited >= WAIT_LIMIT)
				report_timeout("ready");
			waited++;
			@(negedge bclk);
		end
		req         = 1'b1;
		req_addr    = addr;
		req_size    = size;
		req_operand = op;
		model_store(addr, size, op);
		@(negedge bclk);
		req = 1'b0;
	endtask

	task automatic wait_idle(input string name);
		int waited;
		waited = 0;
		while (!idle) begin
			if (waited >= WAIT_LIMIT)
				report_timeout("idle");
			waited++;
			@(negedge bclk);
		end
		check_level({name, " ready after idle"}, 1'b1, ready);
	endtask

	task automatic read_word(input string name, input word_addr_t w);
		rd_addr = w;
		@(negedge bclk);
		check_word($sformatf("%s word %0d", name, w), model_word(w), rd_data);
	endtask

	task automatic readback_all(input string name);
		for (int w = 0; w < NUM_WORDS; w++)
			read_word(name, word_addr_t'(w));
	endtask

	function automatic operand_t random_operand();
		operand_t op;
		op[63:32] = next_random();
		op[31:0]  = next_random();
		return op;
	endfunction

	initial begin
		size_t sz;

		rng_state   = 32'd12966;
		rst_n       = 1'b0;
		req         = 1'b0;
		req_addr    = '0;
		req_size    = size_byte;
		req_operand = '0;
		rd_addr     = '0;

		repeat (10) @(negedge bclk);
		rst_n = 1'b1;
		@(negedge bclk);

		check_level("reset ready", 1'b1, ready);
		check_level("reset idle", 1'b1, idle);

		// Aligned doubles fill every word so the RAM holds known data.
		for (int w = 0; w < NUM_WORDS; w++)
			issue_store(byte_addr_t'(w * 4), size_double, random_operand());
		wait_idle("init");
		readback_all("init");

		for (int rep = 0; rep < 3; rep++) begin
			for (int s = 0; s < 4; s++) begin
				for (int lane = 0; lane < 4; lane++) begin
					logic [31:0] r;
					r  = next_random();
					sz = size_t'(s);
					issue_store({r[3:0], lane[1:0]}, sz, random_operand());
					wait_idle("single");
				end
			end
		end
		readback_all("single");

		// Back-to-back traffic, biased toward quads for the longest splits.
		for (int n = 0; n < 48; n++) begin
			logic [31:0] r;
			r  = next_random();
			sz = r[8] ? size_quad : size_t'(r[1:0]);
			issue_store(r[21:16], sz, random_operand());
		end
		wait_idle("burst");
		readback_all("burst");

		// Stores starting in the last word spill into word 0 and beyond.
		for (int s = 0; s < 4; s++) begin
			for (int lane = 0; lane < 4; lane++) begin
				sz = size_t'(s);
				issue_store({4'hF, lane[1:0]}, sz, random_operand());
				wait_idle("wrap");
				read_word("wrap", 4'hF);
				read_word("wrap", 4'h0);
				read_word("wrap", 4'h1);
			end
		end
		readback_all("final");

		$display("Verification passed");
		$finish;
	end

endmodule

/* wr_aligner.sv */
`timescale 1ns/1ps

module wr_aligner import store_pkg::*; (
	input  pkt_code_t packet,
	input  operand_t  operand,
	input  size_t     size,
	output word_t     wr_data,
	output byte_en_t  byte_en
);

	lane_t            lane;
	logic             last;
	logic             quad_first;
	logic [7:0][7:0]  op_bytes;
	logic [3:0][2:0]  sel;
	logic [3:0][7:0]  data_bytes;
	byte_en_t         hi_mask;
	byte_en_t         lo_mask;

	assign lane    = packet[1:0];
	assign last    = packet[3];
	assign op_bytes = operand;

	// First packet of a quad takes its bytes from the low operand word.
	assign quad_first = (size == size_quad) && (packet[3:2] == 2'b00);

	// Lanes at or above the start lane carry the head of the store. Lanes below it
	// carry the bytes that spilled over from the previous word.
	always_comb begin
		for (int j = 0; j < 4; j++) begin
			sel[j]        = {(j >= lane) ? !quad_first : last, 2'(j - lane)};
			data_bytes[j] = op_bytes[sel[j]];
		end
	end

	assign wr_data = data_bytes;

	assign hi_mask = 4'b1111 << lane; // Lanes from the start lane upward.
	assign lo_mask = ~hi_mask;

	always_comb begin
		case (size)
			size_byte: byte_en = 4'b0001 << lane;
			size_word: begin
				if (lane == 2'd3)
					byte_en = last ? 4'b0001 : 4'b1000;
				else
					byte_en = 4'b0011 << lane;
			end
			size_double: begin
				if (lane == 2'd0)
					byte_en = 4'b1111;
				else
					byte_en = last ? lo_mask : hi_mask;
			end
			size_quad: begin
				if (lane == 2'd0 || packet[3:2] == 2'b01)
					byte_en = 4'b1111;
				else
					byte_en = last ? lo_mask : hi_mask;
			end
			default: byte_en = '0;
		endcase
	end

endmodule

/* write_fifo.sv */
`timescale 1ns/1ps

module write_fifo import store_pkg::*; #(
	parameter int DEPTH = 4
) (
	input  logic    bclk,
	input  logic    rst_n,
	input  logic    push,
	input  packet_t push_pkt,
	input  logic    pop,
	output packet_t head_pkt,
	output logic    full,
	output logic    empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	packet_t          mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Pointers wrap explicitly so that DEPTH need not be a power of two.
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge bclk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge bclk) begin
		if (push)
			mem[wr_ptr] <= push_pkt;
	end

	assign head_pkt = mem[rd_ptr]; // Head is visible while the FIFO is not empty.
	assign full     = (count == CNT_W'(DEPTH));
	assign empty    = (count == '0);

	a_no_push_full: assert property (@(posedge bclk) disable iff (!rst_n)
		push |-> !full)
		else $error("Push into a full FIFO.");

	a_no_pop_empty: assert property (@(posedge bclk) disable iff (!rst_n)
		pop |-> !empty)
		else $error("Pop from an empty FIFO.");

endmodule
